// File: Makefile
TOP = cache_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP) \
		-f sim.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: sim.f
verilog/cache_param_pkg.sv
verilog/cache_tq_pkg.sv
verilog/cache_tq.sv
verilog/fill_timer.sv
verilog/cache_pipe.sv
verilog/cache_top.sv
sim/fm_model.sv
sim/cache_tb.sv

// File: sim/cache_tb.sv
`default_nettype none

module cache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import cache_param_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int FILL_TIMEOUT = 32;
    localparam int NUM_TESTS = 13;
    localparam int NO_ANSWER = -1;
    localparam int MAX_DELAY = 7;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (FILL_TIMEOUT + MAX_DELAY + 10);
    localparam int MEM_WORDS = 1 << (ADDR_W - WORD_SEL_LSB);

    // One table row
    typedef struct packed {
        t_opcode op;
        logic [ADDR_W-1:0] address;
        t_word data;
        int delay;
        logic exp_err;
        int exp_rd;
        logic poke;
    } t_entry;

    logic clk = 1'b0;
    logic rst;
    logic core_valid;
    t_opcode core_opcode;
    logic [ADDR_W-1:0] core_address;
    t_word core_data;
    logic stall;
    logic rsp_valid;
    logic rsp_error;
    t_word rsp_data;
    logic [ADDR_W-1:0] rsp_address;
    logic fm_rd_req;
    logic [ADDR_W-1:0] fm_rd_address;
    logic fm_rd_rsp_valid;
    t_line fm_rd_data;
    logic fm_wr_valid;
    logic [ADDR_W-1:0] fm_wr_address;
    t_word fm_wr_data;
    int fm_delay;

    t_entry tests [NUM_TESTS];
    // Testbench copy of the FM contents
    t_word golden [MEM_WORDS];
    int passed = 0;
    int failed = 0;

    // Pulse counts and last payloads seen on the buses
    int rd_count = 0;
    int wr_count = 0;
    int rsp_count = 0;
    logic [ADDR_W-1:0] last_rd_address;
    logic [ADDR_W-1:0] last_wr_address;
    t_word last_wr_data;
    logic [ADDR_W-1:0] last_rsp_address;
    t_word last_rsp_data;
    logic last_rsp_error;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cache_top #(.NUM_SETS(16), .FILL_TIMEOUT(FILL_TIMEOUT)) uut (.*);

    fm_model fm (.*, .rd_delay(fm_delay));

    // ----------------------------------------
    // Bus monitor
    // ----------------------------------------
    // Sampled on the falling edge where outputs are settled
    always @(negedge clk) begin
        if (fm_rd_req) begin
            rd_count = rd_count + 1;
            last_rd_address = fm_rd_address;
        end
        if (fm_wr_valid) begin
            wr_count = wr_count + 1;
            last_wr_address = fm_wr_address;
            last_wr_data = fm_wr_data;
        end
        if (rsp_valid) begin
            rsp_count = rsp_count + 1;
            last_rsp_address = rsp_address;
            last_rsp_data = rsp_data;
            last_rsp_error = rsp_error;
        end
    end

    task automatic set_entry(input int n, input t_opcode op, input logic [ADDR_W-1:0] address,
                             input t_word data, input int delay, input logic exp_err,
                             input int exp_rd, input logic poke);
        tests[n] = '{op, address, data, delay, exp_err, exp_rd, poke};
    endtask

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------
    task automatic load_table();
        // n, op, address, data, FM delay, error, fm_rd_req count, poke
        set_entry(0, RD_OP, 16'h0104, 32'h0, 5, 1'b0, 1, 1'b0);
        set_entry(1, RD_OP, 16'h0108, 32'h0, 5, 1'b0, 0, 1'b0);
        // Write hit, then read back
        set_entry(2, WR_OP, 16'h0100, 32'hA5A5_0001, 0, 1'b0, 0, 1'b0);
        set_entry(3, RD_OP, 16'h0100, 32'h0, 0, 1'b0, 0, 1'b0);
        // Write miss is not allocated
        set_entry(4, WR_OP, 16'h0230, 32'h1234_5678, 0, 1'b0, 0, 1'b0);
        set_entry(5, RD_OP, 16'h0230, 32'h0, 3, 1'b0, 1, 1'b0);
        // Same index 0 with tags 5 and 1
        set_entry(6, RD_OP, 16'h0504, 32'h0, 2, 1'b0, 1, 1'b0);
        set_entry(7, RD_OP, 16'h0104, 32'h0, 7, 1'b0, 1, 1'b0);
        // FM silent, then recovery
        set_entry(8, RD_OP, 16'h0840, 32'h0, NO_ANSWER, 1'b1, 1, 1'b0);
        set_entry(9, RD_OP, 16'h0840, 32'h0, 4, 1'b0, 1, 1'b0);
        // core_valid pulses under stall
        set_entry(10, RD_OP, 16'h010C, 32'h0, 0, 1'b0, 0, 1'b1);
        set_entry(11, WR_OP, 16'h0508, 32'hC0DE_0B0E, 0, 1'b0, 0, 1'b1);
        set_entry(12, RD_OP, 16'h0508, 32'h0, 0, 1'b0, 1, 1'b0);
    endtask

    task automatic run_entry(input int n);
        int rd_before;
        int wr_before;
        int rsp_before;
        int exp_wr;
        int exp_rsp;
        logic [ADDR_W-WORD_SEL_LSB-1:0] word_idx;
        logic ok;
        word_idx = tests[n].address[ADDR_W-1:WORD_SEL_LSB];
        ok = 1'b1;
        while (stall) begin
            @(posedge clk);
            #10;
        end
        rd_before = rd_count;
        wr_before = wr_count;
        rsp_before = rsp_count;
        fm_delay = tests[n].delay;
        core_valid = 1'b1;
        core_opcode = tests[n].op;
        core_address = tests[n].address;
        core_data = tests[n].data;
        @(posedge clk);
        #10;
        core_valid = 1'b0;
        core_opcode = NOP;
        if (tests[n].poke) begin
            // A miss address that would show on FM if taken
            core_valid = 1'b1;
            core_opcode = RD_OP;
            core_address = 16'hF00C;
            @(posedge clk);
            #10;
            core_valid = 1'b0;
            core_opcode = NOP;
        end
        while (stall) begin
            @(posedge clk);
            #10;
        end

        if (rd_count - rd_before != tests[n].exp_rd) begin
            $display("Fail %0t ns: entry %0d gave %0d fm_rd_req, expected %0d",
                     $time, n, rd_count - rd_before, tests[n].exp_rd);
            ok = 1'b0;
        end
        if (tests[n].exp_rd > 0 &&
            last_rd_address != {tests[n].address[ADDR_W-1:OFFSET_W], OFFSET_W'(0)}) begin
            $display("Fail %0t ns: entry %0d fm_rd_address %h", $time, n, last_rd_address);
            ok = 1'b0;
        end
        exp_wr = (tests[n].op == WR_OP) ? 1 : 0;
        if (wr_count - wr_before != exp_wr) begin
            $display("Fail %0t ns: entry %0d gave %0d fm_wr_valid, expected %0d",
                     $time, n, wr_count - wr_before, exp_wr);
            ok = 1'b0;
        end
        if (exp_wr == 1 && (last_wr_address != tests[n].address ||
                            last_wr_data != tests[n].data)) begin
            $display("Fail %0t ns: entry %0d fm write %h = %h", $time, n,
                     last_wr_address, last_wr_data);
            ok = 1'b0;
        end
        exp_rsp = (tests[n].op == RD_OP) ? 1 : 0;
        if (rsp_count - rsp_before != exp_rsp) begin
            $display("Fail %0t ns: entry %0d gave %0d responses, expected %0d",
                     $time, n, rsp_count - rsp_before, exp_rsp);
            ok = 1'b0;
        end
        if (exp_rsp == 1 && last_rsp_error != tests[n].exp_err) begin
            $display("Fail %0t ns: entry %0d rsp_error %b", $time, n, last_rsp_error);
            ok = 1'b0;
        end
        if (exp_rsp == 1 && !tests[n].exp_err && last_rsp_data != golden[word_idx]) begin
            $display("Fail %0t ns: entry %0d rsp_data %h, expected %h", $time, n,
                     last_rsp_data, golden[word_idx]);
            ok = 1'b0;
        end
        if (exp_rsp == 1 && last_rsp_address != tests[n].address) begin
            $display("Fail %0t ns: entry %0d rsp_address %h", $time, n, last_rsp_address);
            ok = 1'b0;
        end
        // Track FM contents after write-through
        if (tests[n].op == WR_OP) begin
            golden[word_idx] = tests[n].data;
        end
        if (ok) begin
            passed = passed + 1;
        end else begin
            failed = failed + 1;
        end
        $display("Entry %0d %s %h: %s", n, (tests[n].op == WR_OP) ? "write" : "read",
                 tests[n].address, ok ? "ok" : "mismatch");
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rst = 1'b1;
        core_valid = 1'b0;
        core_opcode = NOP;
        core_address = '0;
        core_data = '0;
        fm_delay = 0;
        void'($urandom(32'h3357));
        for (int i = 0; i < MEM_WORDS; i++) begin
            golden[i] = $urandom();
            fm.mem[i] = golden[i];
        end
        load_table();
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;
        for (int n = 0; n < NUM_TESTS; n++) begin
            run_entry(n);
        end
        $display("Entries %0d, passed %0d, failed %0d", NUM_TESTS, passed, failed);
        if (failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Hang guard
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Run hung: no finish after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/fm_model.sv
`default_nettype none

module fm_model (
    input  logic                                 clk,
    input  logic                                 rst,
    input  int                                   rd_delay,
    input  logic                                 fm_rd_req,
    input  logic [cache_param_pkg::ADDR_W-1:0]   fm_rd_address,
    output logic                                 fm_rd_rsp_valid,
    output cache_param_pkg::t_line               fm_rd_data,
    input  logic                                 fm_wr_valid,
    input  logic [cache_param_pkg::ADDR_W-1:0]   fm_wr_address,
    input  cache_param_pkg::t_word               fm_wr_data
);
    timeunit 1ns;
    timeprecision 100ps;

    import cache_param_pkg::*;

    localparam int MEM_WORDS = 1 << (ADDR_W - WORD_SEL_LSB);

    // Golden word array, loaded by the testbench at time zero
    t_word mem [MEM_WORDS];

    // Outstanding read
    logic pending = 1'b0;
    int wait_count = 0;
    logic [ADDR_W-1:0] line_address = '0;
    logic rsp_valid_r = 1'b0;
    t_line rsp_line = '0;

    assign fm_rd_rsp_valid = rsp_valid_r;
    assign fm_rd_data = rsp_line;

    // Gather the four words of one line
    function automatic t_line read_line(input logic [ADDR_W-1:0] address);
        t_line line;
        for (int w = 0; w < NUM_WORDS; w++) begin
            line.words[w] = mem[{address[ADDR_W-1:OFFSET_W], 2'(w)}];
        end
        return line;
    endfunction

    always @(posedge clk) begin
        rsp_valid_r <= 1'b0;
        if (rst) begin
            pending <= 1'b0;
        end else if (fm_rd_req) begin
            // Negative delay, FM never answers
            pending <= (rd_delay >= 0);
            wait_count <= rd_delay;
            line_address <= fm_rd_address;
        end else if (pending) begin
            if (wait_count == 0) begin
                pending <= 1'b0;
                rsp_valid_r <= 1'b1;
                rsp_line <= read_line(line_address);
            end else begin
                wait_count <= wait_count - 1;
            end
        end
        // Write-through word lands in the array
        if (fm_wr_valid) begin
            mem[fm_wr_address[ADDR_W-1:WORD_SEL_LSB]] = fm_wr_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/cache_param_pkg.sv
`default_nettype none

package cache_param_pkg;

    // ----------------------------------------
    // Address split
    // ----------------------------------------

    // Byte address, one word wide
    localparam int ADDR_W = 16;
    // Byte offset inside a line
    localparam int OFFSET_W = 4;
    // Word select sits above the byte-in-word bits
    localparam int WORD_SEL_LSB = 2;

    // ----------------------------------------
    // Line and word formats
    // ----------------------------------------

    localparam int WORD_W = 32;
    localparam int LINE_W = 128;
    localparam int NUM_WORDS = LINE_W / WORD_W;

    typedef logic [WORD_W-1:0] t_word;

    // Same 128 bits, two views
    // Flat view for FM transfers and fills
    // Word view for select and merge, indexed by address bits 3:2
    typedef union packed {
        logic [LINE_W-1:0] flat;
        t_word [NUM_WORDS-1:0] words;
    } t_line;

    // ----------------------------------------
    // Core opcodes
    // ----------------------------------------

    typedef enum logic [1:0] {
        NOP   = 2'b00,
        RD_OP = 2'b01,
        WR_OP = 2'b10
    } t_opcode;

endpackage

`default_nettype wire

// File: verilog/cache_pipe.sv
`default_nettype none

module cache_pipe #(
    parameter int NUM_SETS = 16
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 lu_valid_q1,
    input  cache_tq_pkg::t_lu_op                 lu_op_q1,
    input  logic [cache_param_pkg::ADDR_W-1:0]   lu_address_q1,
    input  cache_param_pkg::t_line               lu_data_q1,
    output logic                                 lu_valid_q3,
    output logic                                 lu_hit_q3,
    output logic [cache_param_pkg::ADDR_W-1:0]   lu_address_q3,
    output cache_param_pkg::t_line               lu_data_q3
);

    import cache_param_pkg::*;
    import cache_tq_pkg::*;

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

    // Direct-mapped arrays
    logic [NUM_SETS-1:0] valid_array;
    logic [TAG_W-1:0] tag_array [NUM_SETS];
    t_line data_array [NUM_SETS];

    // q2 stage
    logic valid_q2;
    t_lu_op op_q2;
    logic [ADDR_W-1:0] address_q2;
    t_line data_q2;
    logic [IDX_W-1:0] idx_q2;
    logic bypass_q2;
    logic rd_valid_q2;
    logic [TAG_W-1:0] rd_tag_q2;
    t_line rd_line_q2;

    // q3 stage
    t_lu_op op_q3;
    t_line wr_data_q3;
    logic [IDX_W-1:0] idx_q3;
    logic [TAG_W-1:0] tag_q3;
    logic upd_en_q3;
    t_line upd_line_q3;

    // ----------------------------------------
    // q1 -> q2
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q2 <= 1'b0;
        end else begin
            valid_q2 <= lu_valid_q1;
        end
        op_q2 <= lu_op_q1;
        address_q2 <= lu_address_q1;
        data_q2 <= lu_data_q1;
    end

    // q2 array read, with bypass from the q3 update to the same set
    assign idx_q2 = address_q2[OFFSET_W +: IDX_W];
    assign bypass_q2 = upd_en_q3 && (idx_q3 == idx_q2);
    assign rd_valid_q2 = bypass_q2 ? 1'b1 : valid_array[idx_q2];
    assign rd_tag_q2 = bypass_q2 ? tag_q3 : tag_array[idx_q2];
    assign rd_line_q2 = bypass_q2 ? upd_line_q3 : data_array[idx_q2];

    // ----------------------------------------
    // q2 -> q3
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            lu_valid_q3 <= 1'b0;
        end else begin
            lu_valid_q3 <= valid_q2;
        end
        op_q3 <= op_q2;
        lu_address_q3 <= address_q2;
        wr_data_q3 <= data_q2;
        lu_hit_q3 <= rd_valid_q2 && (rd_tag_q2 == address_q2[ADDR_W-1 -: TAG_W]);
        lu_data_q3 <= rd_line_q2;
    end

    // q3 update
    assign idx_q3 = lu_address_q3[OFFSET_W +: IDX_W];
    assign tag_q3 = lu_address_q3[ADDR_W-1 -: TAG_W];
    // Fills always write, writes only on a hit (no allocate)
    assign upd_en_q3 = lu_valid_q3 &&
                       ((op_q3 == FILL_LU) || (op_q3 == WR_LU && lu_hit_q3));

    always_comb begin
        upd_line_q3 = lu_data_q3;
        if (op_q3 == FILL_LU) begin
            upd_line_q3 = wr_data_q3;
        end else begin
            // Merge the one addressed word
            upd_line_q3.words[lu_address_q3[OFFSET_W-1:WORD_SEL_LSB]] =
                wr_data_q3.words[lu_address_q3[OFFSET_W-1:WORD_SEL_LSB]];
        end
    end

    always_ff @(posedge clk) begin
        if (upd_en_q3) begin
            tag_array[idx_q3] <= tag_q3;
            data_array[idx_q3] <= upd_line_q3;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_array <= '0;
        end else if (upd_en_q3) begin
            valid_array[idx_q3] <= 1'b1;
        end
    end

    // Fills come from the queue as whole lines
    a_fill_aligned : assert property (@(posedge clk) disable iff (rst)
        (lu_valid_q1 && lu_op_q1 == FILL_LU) |-> (lu_address_q1[OFFSET_W-1:0] == '0));

endmodule

`default_nettype wire

// File: verilog/cache_top.sv
`default_nettype none

module cache_top #(
    parameter int NUM_SETS = 16,
    parameter int FILL_TIMEOUT = 32
) (
    input  logic                                 clk,
    input  logic                                 rst,
    // Core side
    input  logic                                 core_valid,
    input  cache_param_pkg::t_opcode             core_opcode,
    input  logic [cache_param_pkg::ADDR_W-1:0]   core_address,
    input  cache_param_pkg::t_word               core_data,
    output logic                                 stall,
    output logic                                 rsp_valid,
    output logic                                 rsp_error,
    output cache_param_pkg::t_word               rsp_data,
    output logic [cache_param_pkg::ADDR_W-1:0]   rsp_address,
    // FM side
    output logic                                 fm_rd_req,
    output logic [cache_param_pkg::ADDR_W-1:0]   fm_rd_address,
    input  logic                                 fm_rd_rsp_valid,
    input  cache_param_pkg::t_line               fm_rd_data,
    output logic                                 fm_wr_valid,
    output logic [cache_param_pkg::ADDR_W-1:0]   fm_wr_address,
    output cache_param_pkg::t_word               fm_wr_data
);

    import cache_param_pkg::*;
    import cache_tq_pkg::*;

    // Queue to pipeline
    logic lu_valid_q1;
    t_lu_op lu_op_q1;
    logic [ADDR_W-1:0] lu_address_q1;
    t_line lu_data_q1;

    // Pipeline back to queue
    logic lu_valid_q3;
    logic lu_hit_q3;
    logic [ADDR_W-1:0] lu_address_q3;
    t_line lu_data_q3;

    // Fill wait handshake
    logic wait_fill;
    logic fill_expired;

    cache_tq u_cache_tq (.*);

    fill_timer #(.FILL_TIMEOUT(FILL_TIMEOUT)) u_fill_timer (.*);

    cache_pipe #(.NUM_SETS(NUM_SETS)) u_cache_pipe (.*);

endmodule

`default_nettype wire

// File: verilog/cache_tq.sv
`default_nettype none

module cache_tq (
    input  logic                                 clk,
    input  logic                                 rst,
    // Core interface
    input  logic                                 core_valid,
    input  cache_param_pkg::t_opcode             core_opcode,
    input  logic [cache_param_pkg::ADDR_W-1:0]   core_address,
    input  cache_param_pkg::t_word               core_data,
    output logic                                 stall,
    output logic                                 rsp_valid,
    output logic                                 rsp_error,
    output cache_param_pkg::t_word               rsp_data,
    output logic [cache_param_pkg::ADDR_W-1:0]   rsp_address,
    // FM interface
    output logic                                 fm_rd_req,
    output logic [cache_param_pkg::ADDR_W-1:0]   fm_rd_address,
    input  logic                                 fm_rd_rsp_valid,
    input  cache_param_pkg::t_line               fm_rd_data,
    output logic                                 fm_wr_valid,
    output logic [cache_param_pkg::ADDR_W-1:0]   fm_wr_address,
    output cache_param_pkg::t_word               fm_wr_data,
    // Pipe interface
    output logic                                 lu_valid_q1,
    output cache_tq_pkg::t_lu_op                 lu_op_q1,
    output logic [cache_param_pkg::ADDR_W-1:0]   lu_address_q1,
    output cache_param_pkg::t_line               lu_data_q1,
    input  logic                                 lu_valid_q3,
    input  logic                                 lu_hit_q3,
    input  logic [cache_param_pkg::ADDR_W-1:0]   lu_address_q3,
    input  cache_param_pkg::t_line               lu_data_q3,
    // Fill timer
    output logic                                 wait_fill,
    input  logic                                 fill_expired
);

    import cache_param_pkg::*;
    import cache_tq_pkg::*;

    t_tq_state state;
    t_tq_state next_state;

    logic accept;
    logic [ADDR_W-1:0] req_address;
    logic [ADDR_W-1:0] line_address;
    t_word req_data;
    t_word rsp_word;
    t_line fill_line;

    assign accept = core_valid && !stall;
    // Fills and FM reads are whole lines
    assign line_address = {req_address[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: begin
                // NOP requests leave the queue idle
                if (accept && core_opcode == RD_OP) begin
                    next_state = CORE_RD_REQ;
                end else if (accept && core_opcode == WR_OP) begin
                    next_state = CORE_WR_REQ;
                end
            end
            CORE_WR_REQ: next_state = LU_CORE_WR_REQ;
            LU_CORE_WR_REQ: begin
                if (lu_valid_q3) begin
                    next_state = IDLE;
                end
            end
            CORE_RD_REQ: next_state = LU_CORE_RD_REQ;
            LU_CORE_RD_REQ: begin
                if (lu_valid_q3) begin
                    next_state = lu_hit_q3 ? CORE_RD_RSP : WAIT_FILL;
                end
            end
            CORE_RD_RSP: next_state = IDLE;
            WAIT_FILL: begin
                // FM answer wins over a timeout in the same cycle
                if (fm_rd_rsp_valid) begin
                    next_state = FILL;
                end else if (fill_expired) begin
                    next_state = ERROR;
                end
            end
            FILL: next_state = LU_FILL;
            // Replay the read once the fill has landed
            LU_FILL: begin
                if (lu_valid_q3) begin
                    next_state = CORE_RD_REQ;
                end
            end
            ERROR: next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            fm_rd_req <= 1'b0;
        end else begin
            state <= next_state;
            // One pulse on entry to WAIT_FILL
            fm_rd_req <= (state == LU_CORE_RD_REQ) && lu_valid_q3 && !lu_hit_q3;
        end
    end

    // Request, response and fill payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_address <= core_address;
            req_data <= core_data;
        end
        if (state == LU_CORE_RD_REQ && lu_valid_q3 && lu_hit_q3) begin
            rsp_word <= lu_data_q3.words[lu_address_q3[OFFSET_W-1:WORD_SEL_LSB]];
        end
        if (state == WAIT_FILL && next_state == ERROR) begin
            rsp_word <= '0;
        end
        if (state == WAIT_FILL && fm_rd_rsp_valid) begin
            fill_line <= fm_rd_data;
        end
    end

    // ----------------------------------------
    // Outputs decoded from state
    // ----------------------------------------
    assign stall = (state != IDLE);
    assign wait_fill = (state == WAIT_FILL);

    assign rsp_valid = (state == CORE_RD_RSP) || (state == ERROR);
    assign rsp_error = (state == ERROR);
    assign rsp_data = rsp_word;
    assign rsp_address = req_address;

    assign fm_rd_address = line_address;
    // Write-through issued alongside the write lookup
    assign fm_wr_valid = (state == CORE_WR_REQ);
    assign fm_wr_address = req_address;
    assign fm_wr_data = req_data;

    assign lu_valid_q1 = (state == CORE_WR_REQ) || (state == CORE_RD_REQ) || (state == FILL);
    assign lu_op_q1 = (state == CORE_WR_REQ) ? WR_LU :
                      (state == CORE_RD_REQ) ? RD_LU :
                      (state == FILL)        ? FILL_LU : NO_LU;
    assign lu_address_q1 = (state == FILL) ? line_address : req_address;
    // Write word replicated over the line for the pipe to merge
    assign lu_data_q1 = (state == FILL) ? fill_line : t_line'({NUM_WORDS{req_data}});

    // Lookups return only while the queue waits for one
    a_lookup_expected : assert property (@(posedge clk) disable iff (rst)
        lu_valid_q3 |-> ((state == LU_CORE_WR_REQ) || (state == LU_CORE_RD_REQ) ||
                         (state == LU_FILL)));

    // Core lookups come back with the request address
    a_lookup_address : assert property (@(posedge clk) disable iff (rst)
        (lu_valid_q3 && state != LU_FILL) |-> (lu_address_q3 == req_address));

endmodule

`default_nettype wire

// File: verilog/cache_tq_pkg.sv
`default_nettype none

package cache_tq_pkg;

    // Operation carried down the lookup pipeline
    typedef enum logic [1:0] {
        NO_LU   = 2'b00,
        RD_LU   = 2'b01,
        WR_LU   = 2'b10,
        FILL_LU = 2'b11
    } t_lu_op;

    // Transaction queue states
    typedef enum logic [3:0] {
        IDLE           = 4'd0,
        CORE_WR_REQ    = 4'd1,
        LU_CORE_WR_REQ = 4'd2,
        CORE_RD_REQ    = 4'd3,
        LU_CORE_RD_REQ = 4'd4,
        CORE_RD_RSP    = 4'd5,
        WAIT_FILL      = 4'd6,
        FILL           = 4'd7,
        LU_FILL        = 4'd8,
        ERROR          = 4'd9
    } t_tq_state;

endpackage

`default_nettype wire

// File: verilog/fill_timer.sv
`default_nettype none

module fill_timer #(
    parameter int FILL_TIMEOUT = 32
) (
    input  logic clk,
    input  logic rst,
    input  logic wait_fill,
    output logic fill_expired
);

    localparam int CNT_W = $clog2(FILL_TIMEOUT + 1);

    logic [CNT_W-1:0] count;
    logic count_done;

    // Saturating wait counter
    // Cleared whenever the queue is not waiting
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (!wait_fill) begin
            count <= '0;
        end else if (!count_done) begin
            count <= count + 1'b1;
        end
    end

    assign count_done = (count == CNT_W'(FILL_TIMEOUT));
    // Stale count from the last wait must not leak out
    assign fill_expired = wait_fill && count_done;

    // Expiry only after a full wait
    a_expiry_after_wait : assert property (@(posedge clk) disable iff (rst)
        fill_expired |-> $past(wait_fill, FILL_TIMEOUT));

endmodule

`default_nettype wire
